//--- source/input_pkg.sv
// Player input definitions
`default_nettype none

package input_pkg;

    // ==========================================================
    // Widths with a meaning
    // ==========================================================
    typedef logic [15:0] player_word_t;  // Raw control word per player
    typedef logic [7:0]  kb_dir_t;       // Keyboard directions and buttons
    typedef logic [9:0]  game_ctrl_t;    // Low bits handed to the game
    typedef logic [7:0]  analog_t;       // Two's complement analog value
    typedef logic [8:0]  spinner_t;      // Toggle bit 8, signed delta below
    typedef logic [2:0]  sens_t;         // Rotary sensitivity code
    typedef logic [7:0]  dsw_t;          // One DIP-switch byte
    typedef logic [24:0] dl_addr_t;      // Download stream address

    // Button positions inside player_word_t
    localparam int BTN_START = 10;
    localparam int BTN_COIN  = 11;
    localparam int BTN_PAUSE = 12;

    localparam int NUM_PLAYERS = 4;

    // Fixed analog sources
    localparam analog_t DPAD_RIGHT_VAL = 8'h40;
    localparam analog_t DPAD_LEFT_VAL  = 8'hC0;
    localparam analog_t PADDLE_CENTRE  = 8'h7F;

    // ==========================================================
    // Analog mode and bundles
    // ==========================================================
    typedef enum logic [1:0] {
        ANALOG_JOYSTICK = 2'd0,
        ANALOG_PADDLE   = 2'd1,
        ANALOG_SPINNER  = 2'd2,
        ANALOG_DPAD     = 2'd3
    } analog_mode_e;

    typedef struct packed {
        analog_t  joy_x_p1;
        analog_t  joy_x_p2;
        analog_t  paddle_p1;
        analog_t  paddle_p2;
        spinner_t spin_p1;
        spinner_t spin_p2;
    } analog_in_t;

    typedef struct packed {
        analog_mode_e mode;
        sens_t        sens;
        logic         invert;   // Complement nonzero results
    } analog_cfg_t;

    typedef struct packed {
        analog_t p1;
        analog_t p2;
        logic    abs;           // Absolute position modes
        logic    inc;           // Spinner moved this cycle
    } analog_out_t;

    // Download stream write, one-cycle strobe
    typedef struct packed {
        logic       wr;
        logic [7:0] index;
        dl_addr_t   addr;
        dsw_t       data;
    } dl_wr_t;

endpackage

`default_nettype wire

//--- source/player_merge.sv
// Player control merge
`timescale 1ns/1ps
`default_nettype none

module player_merge (
    input  wire input_pkg::player_word_t [input_pkg::NUM_PLAYERS-1:0] joystick,
    input  wire input_pkg::kb_dir_t      [input_pkg::NUM_PLAYERS-1:0] kb_dir,
    input  wire [input_pkg::NUM_PLAYERS-1:0]                          kb_start,
    input  wire [input_pkg::NUM_PLAYERS-1:0]                          kb_coin,
    input  wire                                                       kb_pause,

    output input_pkg::player_word_t      [input_pkg::NUM_PLAYERS-1:0] merged,
    output input_pkg::game_ctrl_t        [input_pkg::NUM_PLAYERS-1:0] game_ctrl,
    output logic [input_pkg::NUM_PLAYERS-1:0]                         start,
    output logic [input_pkg::NUM_PLAYERS-1:0]                         coin,
    output logic                                                      pause_button
);

    import input_pkg::*;

    // Keyboard controls laid out like a joystick word
    function automatic player_word_t kb_word_of(
        input kb_dir_t dir,
        input logic    start_bit,
        input logic    coin_bit,
        input logic    pause_bit
    );
        player_word_t w;
        w            = '0;
        w[7:0]       = dir;
        w[BTN_START] = start_bit;
        w[BTN_COIN]  = coin_bit;
        w[BTN_PAUSE] = pause_bit;   // Shared by all players
        return w;
    endfunction

    player_word_t [NUM_PLAYERS-1:0] kb_word;
    logic         [NUM_PLAYERS-1:0] pause_bits;

    // ==========================================================
    // Per player merge
    // ==========================================================
    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        assign kb_word[p] = kb_word_of(kb_dir[p], kb_start[p], kb_coin[p], kb_pause);

        // Either source can press a button
        assign merged[p] = joystick[p] | kb_word[p];

        assign game_ctrl[p]  = merged[p][9:0];
        assign start[p]      = merged[p][BTN_START];
        assign coin[p]       = merged[p][BTN_COIN];   // Level, no pulse shaping
        assign pause_bits[p] = merged[p][BTN_PAUSE];
    end

    // Any player can pause
    assign pause_button = |pause_bits;

endmodule

`default_nettype wire

//--- source/analog_cond.sv
// Analog input conditioning
`timescale 1ns/1ps
`default_nettype none

module analog_cond (
    input  wire                                                       clk_sys,
    input  wire                                                       arst_n,
    input  wire input_pkg::analog_in_t                                analog_in,
    input  wire input_pkg::analog_cfg_t                               analog_cfg,
    input  wire input_pkg::player_word_t [input_pkg::NUM_PLAYERS-1:0] merged,
    output input_pkg::analog_out_t                                    analog_out
);

    import input_pkg::*;

    // ==========================================================
    // Sensitivity and inversion
    // ==========================================================
    function automatic analog_t scale_value(
        input analog_t value,
        input sens_t   code,
        input logic    invert
    );
        logic signed [7:0] sval;
        analog_t           half;
        analog_t           quarter;
        analog_t           res;
        sval    = value;
        half    = sval >>> 1;
        quarter = sval >>> 2;
        unique case (code)
            3'd0: res = value;
            3'd1: res = half;
            3'd2: res = quarter;
            3'd3: res = sval >>> 3;
            3'd4: res = sval >>> 4;
            3'd5: res = value + value;     // 200%
            3'd6: res = value + half;      // 150%
            3'd7: res = value + quarter;   // 125%
        endcase
        // Zero keeps its meaning of no movement
        if (invert && (res != '0)) begin
            res = ~res;
        end
        return res;
    endfunction

    // D-pad right wins over left
    function automatic analog_t dpad_value(input player_word_t w);
        analog_t v;
        if (w[0]) begin
            v = DPAD_RIGHT_VAL;
        end else if (w[1]) begin
            v = DPAD_LEFT_VAL;
        end else begin
            v = '0;
        end
        return v;
    endfunction

    logic [1:0]  prev_spin;   // Toggle bits seen on the last clock
    logic [1:0]  spin_chg;
    analog_out_t out_d;

    assign spin_chg[0] = prev_spin[0] ^ analog_in.spin_p1[8];
    assign spin_chg[1] = prev_spin[1] ^ analog_in.spin_p2[8];

    // ==========================================================
    // Source select by mode
    // ==========================================================
    always_comb begin
        out_d = '0;
        unique case (analog_cfg.mode)
            ANALOG_JOYSTICK: begin
                out_d.p1  = scale_value(analog_in.joy_x_p1, analog_cfg.sens, analog_cfg.invert);
                out_d.p2  = scale_value(analog_in.joy_x_p2, analog_cfg.sens, analog_cfg.invert);
                out_d.abs = 1'b1;
            end
            ANALOG_PADDLE: begin
                // Paddle reports around mid scale
                out_d.p1  = scale_value(analog_in.paddle_p1 - PADDLE_CENTRE,
                                        analog_cfg.sens, analog_cfg.invert);
                out_d.p2  = scale_value(analog_in.paddle_p2 - PADDLE_CENTRE,
                                        analog_cfg.sens, analog_cfg.invert);
                out_d.abs = 1'b1;
            end
            ANALOG_SPINNER: begin
                if (spin_chg[0]) begin
                    out_d.p1 = scale_value(analog_in.spin_p1[7:0], analog_cfg.sens,
                                           analog_cfg.invert);
                end
                if (spin_chg[1]) begin
                    out_d.p2 = scale_value(analog_in.spin_p2[7:0], analog_cfg.sens,
                                           analog_cfg.invert);
                end
                out_d.inc = |spin_chg;   // New sample from either player
            end
            ANALOG_DPAD: begin
                out_d.p1  = scale_value(dpad_value(merged[0]), analog_cfg.sens,
                                        analog_cfg.invert);
                out_d.p2  = scale_value(dpad_value(merged[1]), analog_cfg.sens,
                                        analog_cfg.invert);
                out_d.abs = 1'b1;
            end
        endcase
    end

    // Toggle history runs in every mode
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            prev_spin  <= '0;
            analog_out <= '0;
        end else begin
            prev_spin  <= {analog_in.spin_p2[8], analog_in.spin_p1[8]};
            analog_out <= out_d;
        end
    end

endmodule

`default_nettype wire

//--- source/dip_regs.sv
// DIP switch store
`timescale 1ns/1ps
`default_nettype none

module dip_regs #(
    parameter logic [7:0] DIP_INDEX = 8'd254   // Download index of the DIP block
) (
    input  wire                   clk_sys,
    input  wire                   arst_n,
    input  wire input_pkg::dl_wr_t dl_wr,
    output input_pkg::dsw_t        dswa,
    output input_pkg::dsw_t        dswb
);

    import input_pkg::*;

    // Bytes as downloaded, switches are active low
    dsw_t dsw_a_n;
    dsw_t dsw_b_n;
    logic dip_hit;

    // Only addresses 0 and 1 carry switches
    assign dip_hit = dl_wr.wr
                     && (dl_wr.index == DIP_INDEX)
                     && (dl_wr.addr[$bits(dl_addr_t)-1:1] == '0);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            dsw_a_n <= '0;
            dsw_b_n <= '0;
        end else if (dip_hit) begin
            if (dl_wr.addr[0]) begin
                dsw_b_n <= dl_wr.data;
            end else begin
                dsw_a_n <= dl_wr.data;
            end
        end
    end

    // ==========================================================
    // Toward the game
    // ==========================================================
    assign dswa = ~dsw_a_n;
    assign dswb = ~dsw_b_n;   // All off after reset

endmodule

`default_nettype wire

//--- source/input_frontend.sv
// Player input front end
`timescale 1ns/1ps
`default_nettype none

module input_frontend #(
    parameter logic [7:0] DIP_INDEX = 8'd254
) (
    input  wire                                                       clk_sys,
    input  wire                                                       arst_n,

    // Player controls
    input  wire input_pkg::player_word_t [input_pkg::NUM_PLAYERS-1:0] joystick,
    input  wire input_pkg::kb_dir_t      [input_pkg::NUM_PLAYERS-1:0] kb_dir,
    input  wire [input_pkg::NUM_PLAYERS-1:0]                          kb_start,
    input  wire [input_pkg::NUM_PLAYERS-1:0]                          kb_coin,
    input  wire                                                       kb_pause,

    // Analog channels
    input  wire input_pkg::analog_in_t                                analog_in,
    input  wire input_pkg::analog_cfg_t                               analog_cfg,

    // Download stream
    input  wire input_pkg::dl_wr_t                                    dl_wr,

    // To the game
    output input_pkg::game_ctrl_t        [input_pkg::NUM_PLAYERS-1:0] game_ctrl,
    output logic [input_pkg::NUM_PLAYERS-1:0]                         start,
    output logic [input_pkg::NUM_PLAYERS-1:0]                         coin,
    output logic                                                      pause_button,
    output input_pkg::analog_out_t                                    analog_out,
    output input_pkg::dsw_t                                           dswa,
    output input_pkg::dsw_t                                           dswb
);

    import input_pkg::*;

    // Merged words also feed the d-pad source
    player_word_t [NUM_PLAYERS-1:0] merged;

    // ==========================================================
    // Control merge
    // ==========================================================
    player_merge u_player_merge (
        .joystick     (joystick),
        .kb_dir       (kb_dir),
        .kb_start     (kb_start),
        .kb_coin      (kb_coin),
        .kb_pause     (kb_pause),
        .merged       (merged),
        .game_ctrl    (game_ctrl),
        .start        (start),
        .coin         (coin),
        .pause_button (pause_button)
    );

    // ==========================================================
    // Analog conditioning
    // ==========================================================
    analog_cond u_analog_cond (
        .clk_sys    (clk_sys),
        .arst_n     (arst_n),
        .analog_in  (analog_in),
        .analog_cfg (analog_cfg),
        .merged     (merged),
        .analog_out (analog_out)
    );

    // ==========================================================
    // DIP switches
    // ==========================================================
    dip_regs #(
        .DIP_INDEX (DIP_INDEX)
    ) u_dip_regs (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .dl_wr   (dl_wr),
        .dswa    (dswa),
        .dswb    (dswb)
    );

endmodule

`default_nettype wire

//--- sim/input_frontend_assertions.sv
// Input front end assertions
`timescale 1ns/1ps
`default_nettype none

module input_frontend_assertions (
    input wire                          clk_sys,
    input wire                          arst_n,
    input wire input_pkg::analog_cfg_t  analog_cfg,
    input wire input_pkg::analog_out_t  analog_out,
    input wire input_pkg::dsw_t         dswa,
    input wire input_pkg::dsw_t         dswb
);

    import input_pkg::*;

    // All switches read as off while in reset
    a_dsw_reset: assert property (@(posedge clk_sys)
        !arst_n |-> ((dswa == 8'hFF) && (dswb == 8'hFF)))
        else $error("DIP bytes not 0xFF during reset");

    a_abs_inc_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
        !(analog_out.abs && analog_out.inc))
        else $error("abs and inc high together");

    // Output is registered, so the mode of the last clock applies
    a_inc_mode: assert property (@(posedge clk_sys) disable iff (!arst_n)
        analog_out.inc |-> ($past(analog_cfg.mode) == ANALOG_SPINNER))
        else $error("inc high outside spinner mode");

    a_zero_after_rst: assert property (@(posedge clk_sys)
        $rose(arst_n) |-> (analog_out == '0))
        else $error("analog outputs not zero after reset release");

endmodule

bind input_frontend input_frontend_assertions u_assertions (
    .clk_sys    (clk_sys),
    .arst_n     (arst_n),
    .analog_cfg (analog_cfg),
    .analog_out (analog_out),
    .dswa       (dswa),
    .dswb       (dswb)
);

`default_nettype wire

//--- sim/tb_input_frontend.sv
// Input front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_input_frontend;

    import input_pkg::*;

    localparam logic [7:0]  DIP_INDEX    = 8'd254;
    localparam int          RESET_CYCLES = 10;
    localparam logic [15:0] LFSR_SEED    = 16'd40797;
    localparam logic [15:0] LFSR_TAPS    = 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1

    logic                           clk_sys;
    logic                           arst_n;
    player_word_t [NUM_PLAYERS-1:0] joystick;
    kb_dir_t      [NUM_PLAYERS-1:0] kb_dir;
    logic         [NUM_PLAYERS-1:0] kb_start;
    logic         [NUM_PLAYERS-1:0] kb_coin;
    logic                           kb_pause;
    analog_in_t                     analog_in;
    analog_cfg_t                    analog_cfg;
    dl_wr_t                         dl_wr;
    game_ctrl_t   [NUM_PLAYERS-1:0] game_ctrl;
    logic         [NUM_PLAYERS-1:0] start;
    logic         [NUM_PLAYERS-1:0] coin;
    logic                           pause_button;
    analog_out_t                    analog_out;
    dsw_t                           dswa;
    dsw_t                           dswb;

    logic [15:0]  lfsr;
    int           checks_done = 0;
    analog_out_t  exp_analog;     // Expected for the next sample
    logic [1:0]   spin_model;     // Toggle bits seen on the last clock
    dsw_t         shadow_a_n;
    dsw_t         shadow_b_n;
    analog_mode_e abs_modes [3] = '{ANALOG_JOYSTICK, ANALOG_PADDLE, ANALOG_DPAD};

    input_frontend #(.DIP_INDEX(DIP_INDEX)) u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // ==========================================================
    // Random source and reference model
    // ==========================================================
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic player_word_t ref_merge(player_word_t joy, kb_dir_t dir,
                                               logic st, logic cn, logic ps);
        player_word_t w;
        w            = joy;
        w[7:0]       = joy[7:0] | dir;
        w[BTN_START] = joy[BTN_START] | st;
        w[BTN_COIN]  = joy[BTN_COIN] | cn;
        w[BTN_PAUSE] = joy[BTN_PAUSE] | ps;
        return w;
    endfunction

    function automatic analog_t ref_scale(analog_t raw, sens_t code, logic inv);
        int      v;
        int      r;
        analog_t res;
        v = $signed(raw);
        case (code)
            3'd0:    r = v;
            3'd5:    r = 2 * v;
            3'd6:    r = v + (v >>> 1);
            3'd7:    r = v + (v >>> 2);
            default: r = v >>> code;   // Codes 1 to 4
        endcase
        res = r[7:0];
        if (inv && (res != 8'h00)) begin
            res = ~res;
        end
        return res;
    endfunction

    function automatic analog_t ref_dpad(player_word_t w);
        return w[0] ? DPAD_RIGHT_VAL : (w[1] ? DPAD_LEFT_VAL : 8'h00);
    endfunction

    function automatic analog_out_t ref_analog(analog_in_t ain, analog_cfg_t cfg,
                                               player_word_t w1, player_word_t w2,
                                               logic [1:0] prev);
        analog_out_t o;
        logic        ch1;
        logic        ch2;
        o   = '0;
        ch1 = (ain.spin_p1[8] != prev[0]);
        ch2 = (ain.spin_p2[8] != prev[1]);
        case (cfg.mode)
            ANALOG_JOYSTICK: begin
                o.p1  = ref_scale(ain.joy_x_p1, cfg.sens, cfg.invert);
                o.p2  = ref_scale(ain.joy_x_p2, cfg.sens, cfg.invert);
                o.abs = 1'b1;
            end
            ANALOG_PADDLE: begin
                o.p1  = ref_scale(analog_t'(ain.paddle_p1 - PADDLE_CENTRE), cfg.sens, cfg.invert);
                o.p2  = ref_scale(analog_t'(ain.paddle_p2 - PADDLE_CENTRE), cfg.sens, cfg.invert);
                o.abs = 1'b1;
            end
            ANALOG_SPINNER: begin
                o.p1  = ch1 ? ref_scale(ain.spin_p1[7:0], cfg.sens, cfg.invert) : 8'h00;
                o.p2  = ch2 ? ref_scale(ain.spin_p2[7:0], cfg.sens, cfg.invert) : 8'h00;
                o.inc = ch1 | ch2;
            end
            default: begin
                o.p1  = ref_scale(ref_dpad(w1), cfg.sens, cfg.invert);
                o.p2  = ref_scale(ref_dpad(w2), cfg.sens, cfg.invert);
                o.abs = 1'b1;
            end
        endcase
        return o;
    endfunction

    // ==========================================================
    // Compare tasks
    // ==========================================================
    task automatic stop_run(string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_ctrl(string name, game_ctrl_t act, game_ctrl_t exp);
        if (act !== exp) begin
            $display("Fail t=%0t %s got %h expected %h", $time, name, act, exp);
            stop_run("Game control word does not match the merge rule");
        end
    endtask

    task automatic check_analog(string name, analog_out_t act, analog_out_t exp);
        if (act !== exp) begin
            $display("Fail t=%0t %s got %h expected %h", $time, name, act, exp);
            stop_run("Conditioned analog output does not match");
        end
    endtask

    task automatic check_dsw(string name, dsw_t act, dsw_t exp);
        if (act !== exp) begin
            $display("Fail t=%0t %s got %h expected %h", $time, name, act, exp);
            stop_run("DIP-switch byte does not match");
        end
    endtask

    task automatic check_bits(string name, logic [3:0] act, logic [3:0] exp);
        if (act !== exp) begin
            $display("Fail t=%0t %s got %b expected %b", $time, name, act, exp);
            stop_run("Merged button bits do not match");
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_sys) begin : compare
        player_word_t [NUM_PLAYERS-1:0] m;
        logic         [NUM_PLAYERS-1:0] exp_start;
        logic         [NUM_PLAYERS-1:0] exp_coin;
        logic                           exp_pause;
        if (!arst_n) begin
            exp_analog = '0;
            spin_model = '0;
            shadow_a_n = '0;
            shadow_b_n = '0;
        end else begin
            exp_pause = 1'b0;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                m[p] = ref_merge(joystick[p], kb_dir[p], kb_start[p], kb_coin[p], kb_pause);
                exp_start[p] = m[p][BTN_START];
                exp_coin[p]  = m[p][BTN_COIN];
                exp_pause    = exp_pause | m[p][BTN_PAUSE];
                check_ctrl($sformatf("game_ctrl[%0d]", p), game_ctrl[p], m[p][9:0]);
            end
            check_bits("start", start, exp_start);
            check_bits("coin", coin, exp_coin);
            check_bits("pause_button", {3'b000, pause_button}, {3'b000, exp_pause});
            check_analog("analog_out", analog_out, exp_analog);
            check_dsw("dswa", dswa, ~shadow_a_n);
            check_dsw("dswb", dswb, ~shadow_b_n);
            exp_analog = ref_analog(analog_in, analog_cfg, m[0], m[1], spin_model);
            spin_model = {analog_in.spin_p2[8], analog_in.spin_p1[8]};
            if (dl_wr.wr && (dl_wr.index == DIP_INDEX) && (dl_wr.addr == 25'd0)) begin
                shadow_a_n = dl_wr.data;
            end
            if (dl_wr.wr && (dl_wr.index == DIP_INDEX) && (dl_wr.addr == 25'd1)) begin
                shadow_b_n = dl_wr.data;
            end
            checks_done++;
        end
    end

    // ==========================================================
    // Stimulus helpers
    // ==========================================================
    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    task automatic randomize_inputs(logic with_spin);
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            joystick[p] = take_bits(16);
            kb_dir[p]   = take_bits(8);
        end
        kb_start           = take_bits(4);
        kb_coin            = take_bits(4);
        kb_pause           = take_bits(1);
        analog_in.joy_x_p1 = take_bits(8);
        analog_in.joy_x_p2 = take_bits(8);
        analog_in.paddle_p1 = take_bits(8);
        analog_in.paddle_p2 = take_bits(8);
        analog_in.spin_p1[7:0] = take_bits(8);
        analog_in.spin_p2[7:0] = take_bits(8);
        if (with_spin) begin
            analog_in.spin_p1[8] = take_bits(1);
            analog_in.spin_p2[8] = take_bits(1);
        end
    endtask

    task automatic dip_write(logic [7:0] index, dl_addr_t addr, dsw_t data);
        next_cycle();
        dl_wr = '{wr: 1'b1, index: index, addr: addr, data: data};
        next_cycle();
        dl_wr.wr   = 1'b0;
        dl_wr.data = take_bits(8);   // Must not land without the strobe
    endtask

    task automatic wait_checks(string phase);
        int target;
        int waited;
        target = checks_done + 2;
        waited = 0;
        while ((checks_done < target) && (waited < 20)) begin
            @(posedge clk_sys);
            waited++;
        end
        if (checks_done < target) begin
            stop_run($sformatf("Timeout: compare process stalled in %s phase", phase));
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        lfsr       = LFSR_SEED;
        arst_n     = 1'b0;
        joystick   = '0;
        kb_dir     = '0;
        kb_start   = '0;
        kb_coin    = '0;
        kb_pause   = 1'b0;
        analog_in  = '0;
        analog_cfg = '{mode: ANALOG_JOYSTICK, sens: 3'd0, invert: 1'b0};
        dl_wr      = '0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #2;
        arst_n = 1'b1;
        wait_checks("reset");

        // DIP writes, valid ones first, then a random mix
        dip_write(DIP_INDEX, 25'd0, take_bits(8));
        dip_write(DIP_INDEX, 25'd1, take_bits(8));
        dip_write(8'd253, 25'd0, take_bits(8));
        dip_write(DIP_INDEX, 25'd2, take_bits(8));
        for (int i = 0; i < 40; i++) begin
            dip_write(take_bits(1) ? DIP_INDEX : 8'(take_bits(8)),
                      take_bits(1) ? 25'(take_bits(1)) : 25'(take_bits(25)), take_bits(8));
        end
        wait_checks("DIP");

        for (int i = 0; i < 200; i++) begin
            next_cycle();
            randomize_inputs(1'b1);
        end
        wait_checks("merge");

        foreach (abs_modes[k]) begin
            for (int s = 0; s < 8; s++) begin
                next_cycle();
                analog_cfg = '{mode: abs_modes[k], sens: sens_t'(s), invert: take_bits(1)};
                for (int i = 0; i < 16; i++) begin
                    randomize_inputs(1'b1);
                    next_cycle();
                end
            end
        end
        wait_checks("absolute analog");

        for (int s = 0; s < 8; s++) begin
            next_cycle();
            analog_cfg = '{mode: ANALOG_SPINNER, sens: sens_t'(s), invert: take_bits(1)};
            for (int i = 0; i < 16; i++) begin
                randomize_inputs(1'b0);
                analog_in.spin_p1[8] = analog_in.spin_p1[8] ^ take_bits(1);
                analog_in.spin_p2[8] = analog_in.spin_p2[8] ^ take_bits(1);
                next_cycle();
            end
            // Toggle bits held, deltas still moving
            for (int i = 0; i < 4; i++) begin
                randomize_inputs(1'b0);
                next_cycle();
            end
        end
        wait_checks("spinner");

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
source/input_pkg.sv
source/player_merge.sv
source/analog_cond.sv
source/dip_regs.sv
source/input_frontend.sv
sim/input_frontend_assertions.sv
sim/tb_input_frontend.sv

//--- Bender.yml
package:
  name: input_frontend

sources:
  # Design sources in compile order
  - files:
      - source/input_pkg.sv
      - source/player_merge.sv
      - source/analog_cond.sv
      - source/dip_regs.sv
      - source/input_frontend.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/input_frontend_assertions.sv
      - sim/tb_input_frontend.sv
